//--- pongGameEngine.f
+incdir+src
src/pongPkg.sv
src/pongFrameSequencer.sv
src/pongCollisionCheck.sv
src/pongBoundedStep.sv
src/pongGameState.sv
src/pongGameEngine.sv
verification/pongGameEngineTb.sv

//--- runSim.sh
#!/bin/sh
# Compile and run the pong engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pongGameEngine.f \
    --top-module pongGameEngineTb -o simPong

output=$(./obj_dir/simPong)
echo "$output"

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- verification/pongGameEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_cfg.svh"

module pongGameEngineTb;

    // Frame spacing and test lengths in frames
    localparam int framePeriod = 12;
    localparam int resetCycles = 16;
    localparam int randomFrames = 60;
    localparam int limitFrames = 60;
    localparam int bothFrames = 3;
    localparam int missFrames = 120;
    // Longest run plus slack for the reset test
    localparam int maxCycles = resetCycles + 20 +
        (randomFrames + limitFrames + bothFrames + missFrames) * framePeriod + 50;

    logic pixIf_CLK;
    logic reset;
    logic pixIf_NEXT_FRAME;
    logic player1YUp;
    logic player1YDown;
    logic player2YUp;
    logic player2YDown;
    logic [`PONG_POS_BITS-1:0] player1Pos;
    logic [`PONG_POS_BITS-1:0] player2Pos;
    logic [`PONG_POS_BITS-1:0] ballXPos;
    logic [`PONG_POS_BITS-1:0] ballYPos;

    // Reference copy of the game state
    int mBx;
    int mBy;
    int mP1;
    int mP2;
    logic mXUp;
    logic mYUp;
    logic lastMiss;

    int seed = 32'h1050;
    int cycleCount;
    int checks;
    int errors;
    int errorsAtStart;
    int testsDone;
    int i;
    int atTop;
    int held;
    logic prevTop;
    logic missSeen;

    pongGameEngine dut0 (
        .pixIf_CLK(pixIf_CLK), .reset(reset), .pixIf_NEXT_FRAME(pixIf_NEXT_FRAME),
        .player1YUp(player1YUp), .player1YDown(player1YDown),
        .player2YUp(player2YUp), .player2YDown(player2YDown),
        .player1Pos(player1Pos), .player2Pos(player2Pos),
        .ballXPos(ballXPos), .ballYPos(ballYPos)
    );

    always #50 pixIf_CLK = ~pixIf_CLK;

    // Run limit
    always @(posedge pixIf_CLK) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic randomBit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // Move by speed, never past the bound in the move direction
    function automatic int moveClamp(input int pos, input logic up, input int speed,
                                     input int bound);
        int n;
        n = up ? pos + speed : pos - speed;
        if (up && n > bound) n = bound;
        if (!up && n < bound) n = bound;
        return n;
    endfunction

    // Paddle and ball share some rows
    function automatic logic covers(input int paddle, input int ballY);
        return (paddle < ballY + `PONG_BALL_SIZE) && (paddle + `PONG_PADDLE_LEN > ballY);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic checkOutputs(input string prefix);
        checkValue({prefix, "ballXPos"}, 32'(ballXPos), mBx);
        checkValue({prefix, "ballYPos"}, 32'(ballYPos), mBy);
        checkValue({prefix, "player1Pos"}, 32'(player1Pos), mP1);
        checkValue({prefix, "player2Pos"}, 32'(player2Pos), mP2);
    endtask

    // One frame of game rules on the model
    task automatic modelFrame(input logic u1, input logic d1, input logic u2, input logic d2);
        logic leftHit;
        logic rightHit;
        leftHit  = mBx <= `PONG_BALL_X_MIN;
        rightHit = mBx >= `PONG_BALL_X_MAX;
        lastMiss = (leftHit && !covers(mP1, mBy)) || (rightHit && !covers(mP2, mBy));
        if (leftHit || rightHit) mXUp = !mXUp;
        if (mBy == 0 || mBy >= `PONG_BALL_Y_MAX) mYUp = !mYUp;
        if (lastMiss) begin
            mP1 = `PONG_PADDLE_START;
            mP2 = `PONG_PADDLE_START;
            mBx = mXUp ? `PONG_SERVE_X_P2 : `PONG_SERVE_X_P1;
        end else begin
            mBx = moveClamp(mBx, mXUp, `PONG_BALL_SPEED,
                            mXUp ? `PONG_BALL_X_MAX : `PONG_BALL_X_MIN);
            mBy = moveClamp(mBy, mYUp, `PONG_BALL_SPEED, mYUp ? `PONG_BALL_Y_MAX : 0);
            // Paddle stays put when both or neither button is held
            if (u1 != d1) mP1 = moveClamp(mP1, u1, `PONG_PADDLE_SPEED, u1 ? `PONG_PADDLE_MAX : 0);
            if (u2 != d2) mP2 = moveClamp(mP2, u2, `PONG_PADDLE_SPEED, u2 ? `PONG_PADDLE_MAX : 0);
        end
    endtask

    // Strobe at the drive edge, DUT samples it one edge later
    task automatic runFrame(input logic u1, input logic d1, input logic u2, input logic d2);
        @(posedge pixIf_CLK);
        pixIf_NEXT_FRAME <= 1'b1;
        player1YUp       <= u1;
        player1YDown     <= d1;
        player2YUp       <= u2;
        player2YDown     <= d2;
        // Last cycle before the strobe is sampled
        @(negedge pixIf_CLK);
        checkOutputs("quiet ");
        @(posedge pixIf_CLK);
        pixIf_NEXT_FRAME <= 1'b0;
        modelFrame(u1, d1, u2, d2);
        repeat (8) @(posedge pixIf_CLK);
        @(negedge pixIf_CLK);
        checkOutputs("");
        repeat (framePeriod - 10) @(posedge pixIf_CLK);
    endtask

    task automatic finishTest(input string name);
        if (errors == errorsAtStart) $display("Test %s: passed", name);
        else $display("Test %s: failed with %0d errors", name, errors - errorsAtStart);
        errorsAtStart = errors;
        testsDone++;
    endtask

    initial begin
        pixIf_CLK = 1'b0;
        reset = 1'b1;
        pixIf_NEXT_FRAME = 1'b0;
        player1YUp = 1'b0;
        player1YDown = 1'b0;
        player2YUp = 1'b0;
        player2YDown = 1'b0;
        cycleCount = 0;
        checks = 0;
        errors = 0;
        errorsAtStart = 0;
        testsDone = 0;
        mBx = `PONG_BALL_START_X;
        mBy = `PONG_BALL_START_Y;
        mP1 = `PONG_PADDLE_START;
        mP2 = `PONG_PADDLE_START;
        mXUp = 1'b0;
        mYUp = 1'b0;
        lastMiss = 1'b0;

        repeat (resetCycles) @(posedge pixIf_CLK);
        reset <= 1'b0;
        @(negedge pixIf_CLK);
        checkOutputs("reset ");
        // No strobe, nothing may move
        repeat (8) @(posedge pixIf_CLK);
        @(negedge pixIf_CLK);
        checkOutputs("idle ");
        finishTest("reset values");

        for (i = 0; i < randomFrames; i++) begin
            runFrame(randomBit(), randomBit(), randomBit(), randomBit());
        end
        finishTest("random frames");

        // Paddle 1 held up until it sits at the top for a few frames
        atTop = 0;
        for (i = 0; i < limitFrames && atTop < 4; i++) begin
            prevTop = atTop > 0;
            runFrame(1'b1, 1'b0, randomBit(), randomBit());
            if (lastMiss) begin
                atTop = 0;
            end else begin
                if (prevTop) checkValue("limit player1Pos", 32'(player1Pos), `PONG_PADDLE_MAX);
                if (mP1 == `PONG_PADDLE_MAX) atTop++;
            end
        end
        if (atTop < 4) begin
            $display("Paddle 1 did not settle at its upper limit");
            errors++;
        end
        // Both buttons cancel out
        for (i = 0; i < bothFrames; i++) begin
            held = mP1;
            runFrame(1'b1, 1'b1, randomBit(), randomBit());
            if (!lastMiss) checkValue("both player1Pos", 32'(player1Pos), held);
        end
        finishTest("paddle limits");

        // Paddles parked at opposite ends until the ball gets past one
        missSeen = 1'b0;
        for (i = 0; i < missFrames && !missSeen; i++) begin
            runFrame(1'b1, 1'b0, 1'b0, 1'b1);
            if (lastMiss) begin
                missSeen = 1'b1;
                checkValue("miss player1Pos", 32'(player1Pos), `PONG_PADDLE_START);
                checkValue("miss player2Pos", 32'(player2Pos), `PONG_PADDLE_START);
                checkValue("miss ballXPos", 32'(ballXPos),
                           mXUp ? `PONG_SERVE_X_P2 : `PONG_SERVE_X_P1);
            end
        end
        if (!missSeen) begin
            $display("No miss happened within %0d frames", missFrames);
            errors++;
        end
        finishTest("miss");

        $display("Tests: %0d, checks: %0d, errors: %0d", testsDone, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/pongGameEngine.sv
`timescale 1ns/1ps
`default_nettype none

module pongGameEngine
    import pongPkg::*;
(
    input  logic pixIf_CLK,
    input  logic reset,
    input  logic pixIf_NEXT_FRAME,
    input  logic player1YUp,
    input  logic player1YDown,
    input  logic player2YUp,
    input  logic player2YDown,
    output posT  player1Pos,
    output posT  player2Pos,
    output posT  ballXPos,
    output posT  ballYPos
);

    // Sequencer outputs
    seqPhaseT phase;
    logic     p1Up;
    logic     p1Down;
    logic     p2Up;
    logic     p2Down;

    // Collision flags
    logic sideHit;
    logic bounceHit;
    logic gameOver;

    // Step unit request and result
    logic    stepValid;
    stepSelT stepSel;
    logic    stepUp;
    posT     stepSpeed;
    posT     stepBoundary;
    posT     stepPos;
    logic    resultValid;
    stepSelT resultSel;
    posT     resultPos;

    pongFrameSequencer seq0 (
        .pixIf_CLK(pixIf_CLK), .reset(reset), .pixIf_NEXT_FRAME(pixIf_NEXT_FRAME),
        .player1YUp(player1YUp), .player1YDown(player1YDown),
        .player2YUp(player2YUp), .player2YDown(player2YDown),
        .phase(phase), .p1Up(p1Up), .p1Down(p1Down), .p2Up(p2Up), .p2Down(p2Down)
    );

    pongCollisionCheck coll0 (
        .pixIf_CLK(pixIf_CLK), .reset(reset), .phase(phase),
        .ballXPos(ballXPos), .ballYPos(ballYPos),
        .player1Pos(player1Pos), .player2Pos(player2Pos),
        .sideHit(sideHit), .bounceHit(bounceHit), .gameOver(gameOver)
    );

    // One shared step unit for all four coordinates
    pongBoundedStep step0 (
        .pixIf_CLK(pixIf_CLK), .reset(reset),
        .stepValid(stepValid), .stepSel(stepSel), .stepUp(stepUp),
        .stepSpeed(stepSpeed), .stepBoundary(stepBoundary), .stepPos(stepPos),
        .resultValid(resultValid), .resultSel(resultSel), .resultPos(resultPos)
    );

    pongGameState state0 (
        .pixIf_CLK(pixIf_CLK), .reset(reset), .phase(phase),
        .p1Up(p1Up), .p1Down(p1Down), .p2Up(p2Up), .p2Down(p2Down),
        .sideHit(sideHit), .bounceHit(bounceHit), .gameOver(gameOver),
        .resultValid(resultValid), .resultSel(resultSel), .resultPos(resultPos),
        .stepValid(stepValid), .stepSel(stepSel), .stepUp(stepUp),
        .stepSpeed(stepSpeed), .stepBoundary(stepBoundary), .stepPos(stepPos),
        .ballXPos(ballXPos), .ballYPos(ballYPos),
        .player1Pos(player1Pos), .player2Pos(player2Pos)
    );

endmodule

`default_nettype wire

//--- src/pongGameState.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_cfg.svh"

module pongGameState
    import pongPkg::*;
(
    input  logic     pixIf_CLK,
    input  logic     reset,
    input  seqPhaseT phase,
    input  logic     p1Up,
    input  logic     p1Down,
    input  logic     p2Up,
    input  logic     p2Down,
    input  logic     sideHit,
    input  logic     bounceHit,
    input  logic     gameOver,
    input  logic     resultValid,
    input  stepSelT  resultSel,
    input  posT      resultPos,
    output logic     stepValid,
    output stepSelT  stepSel,
    output logic     stepUp,
    output posT      stepSpeed,
    output posT      stepBoundary,
    output posT      stepPos,
    output posT      ballXPos,
    output posT      ballYPos,
    output posT      player1Pos,
    output posT      player2Pos
);

    // Ball direction, set means increasing coordinate
    logic ballXUp;
    logic ballYUp;

    // Step operands per issue phase, nothing issued after a miss
    always_comb begin
        stepValid    = 1'b0;
        stepSel      = STEP_BALL_X;
        stepUp       = 1'b0;
        stepSpeed    = '0;
        stepBoundary = '0;
        stepPos      = '0;
        case (phase)
            PHASE_ISSUE_BX: begin
                stepValid    = !gameOver;
                stepSel      = STEP_BALL_X;
                stepUp       = ballXUp;
                stepSpeed    = posT'(`PONG_BALL_SPEED);
                stepBoundary = ballXUp ? posT'(`PONG_BALL_X_MAX) : posT'(`PONG_BALL_X_MIN);
                stepPos      = ballXPos;
            end
            PHASE_ISSUE_BY: begin
                stepValid    = !gameOver;
                stepSel      = STEP_BALL_Y;
                stepUp       = ballYUp;
                stepSpeed    = posT'(`PONG_BALL_SPEED);
                stepBoundary = ballYUp ? posT'(`PONG_BALL_Y_MAX) : '0;
                stepPos      = ballYPos;
            end
            // Paddles move by the up button, result is dropped when idle
            PHASE_ISSUE_P1: begin
                stepValid    = !gameOver;
                stepSel      = STEP_PADDLE1;
                stepUp       = p1Up;
                stepSpeed    = posT'(`PONG_PADDLE_SPEED);
                stepBoundary = p1Up ? posT'(`PONG_PADDLE_MAX) : '0;
                stepPos      = player1Pos;
            end
            PHASE_ISSUE_P2: begin
                stepValid    = !gameOver;
                stepSel      = STEP_PADDLE2;
                stepUp       = p2Up;
                stepSpeed    = posT'(`PONG_PADDLE_SPEED);
                stepBoundary = p2Up ? posT'(`PONG_PADDLE_MAX) : '0;
                stepPos      = player2Pos;
            end
            default: ;
        endcase
    end

    // Direction flips, serve and tagged write-back
    always_ff @(posedge pixIf_CLK) begin
        if (reset) begin
            ballXPos   <= posT'(`PONG_BALL_START_X);
            ballYPos   <= posT'(`PONG_BALL_START_Y);
            player1Pos <= posT'(`PONG_PADDLE_START);
            player2Pos <= posT'(`PONG_PADDLE_START);
            ballXUp    <= 1'b0;
            ballYUp    <= 1'b0;
        end else begin
            if (phase == PHASE_TURN) begin
                ballXUp <= ballXUp ^ sideHit;
                ballYUp <= ballYUp ^ bounceHit;
                if (gameOver) begin
                    player1Pos <= posT'(`PONG_PADDLE_START);
                    player2Pos <= posT'(`PONG_PADDLE_START);
                    // Serve position follows the new X direction
                    ballXPos   <= (ballXUp ^ sideHit) ? posT'(`PONG_SERVE_X_P2)
                                                      : posT'(`PONG_SERVE_X_P1);
                end
            end
            if (resultValid) begin
                case (resultSel)
                    STEP_BALL_X:  ballXPos <= resultPos;
                    STEP_BALL_Y:  ballYPos <= resultPos;
                    STEP_PADDLE1: if (p1Up != p1Down) player1Pos <= resultPos;
                    STEP_PADDLE2: if (p2Up != p2Down) player2Pos <= resultPos;
                    default: ;
                endcase
            end
        end
    end

    // Everything stays on the playfield across frames and serves
    assert property (@(posedge pixIf_CLK) disable iff (reset)
        ballXPos >= posT'(`PONG_BALL_X_MIN) && ballXPos <= posT'(`PONG_BALL_X_MAX) &&
        ballYPos <= posT'(`PONG_BALL_Y_MAX) &&
        player1Pos <= posT'(`PONG_PADDLE_MAX) && player2Pos <= posT'(`PONG_PADDLE_MAX));

endmodule

`default_nettype wire

//--- src/pongBoundedStep.sv
`timescale 1ns/1ps
`default_nettype none

module pongBoundedStep
    import pongPkg::*;
(
    input  logic    pixIf_CLK,
    input  logic    reset,
    input  logic    stepValid,
    input  stepSelT stepSel,
    input  logic    stepUp,
    input  posT     stepSpeed,
    input  posT     stepBoundary,
    input  posT     stepPos,
    output logic    resultValid,
    output stepSelT resultSel,
    output posT     resultPos
);

    localparam int sumBits = $bits(posT) + 1;

    // Stage 1 operands
    logic    validQ1;
    stepSelT selQ1;
    logic    upQ1;
    posT     speedQ1;
    posT     boundaryQ1;
    posT     posQ1;

    // Stage 2 raw sum and what the clamp still needs
    logic    upQ2;
    posT     boundaryQ2;
    logic [sumBits-1:0] sumD;
    logic [sumBits-1:0] sumQ2;
    logic    atBound;

    // Wide add or subtract, MSB flags carry or underflow
    assign sumD = upQ1 ? ({1'b0, posQ1} + {1'b0, speedQ1})
                       : ({1'b0, posQ1} - {1'b0, speedQ1});

    // Valid bits of both stages
    always_ff @(posedge pixIf_CLK) begin
        if (reset) begin
            validQ1     <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            validQ1     <= stepValid;
            resultValid <= validQ1;
        end
    end

    // Payload travels alongside, tag included
    always_ff @(posedge pixIf_CLK) begin
        selQ1      <= stepSel;
        upQ1       <= stepUp;
        speedQ1    <= stepSpeed;
        boundaryQ1 <= stepBoundary;
        posQ1      <= stepPos;
        resultSel  <= selQ1;
        upQ2       <= upQ1;
        boundaryQ2 <= boundaryQ1;
        sumQ2      <= sumD;
    end

    // Saturate at the bound in the move direction
    always_comb begin
        if (upQ2) begin
            atBound = sumQ2 >= {1'b0, boundaryQ2};
        end else begin
            atBound = sumQ2[sumBits-1] || (sumQ2[sumBits-2:0] <= boundaryQ2);
        end
    end

    assign resultPos = atBound ? boundaryQ2 : sumQ2[sumBits-2:0];

    // Upward move lands between its start and the bound it was issued with
    assert property (@(posedge pixIf_CLK) disable iff (reset)
        stepValid && stepUp |-> ##2 (resultValid && resultPos >= $past(stepPos, 2) &&
                                     resultPos <= $past(stepBoundary, 2)));

endmodule

`default_nettype wire

//--- src/pongCollisionCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_cfg.svh"

module pongCollisionCheck
    import pongPkg::*;
(
    input  logic     pixIf_CLK,
    input  logic     reset,
    input  seqPhaseT phase,
    input  posT      ballXPos,
    input  posT      ballYPos,
    input  posT      player1Pos,
    input  posT      player2Pos,
    output logic     sideHit,
    output logic     bounceHit,
    output logic     gameOver
);

    // One extra bit so the end points cannot wrap
    logic [`PONG_POS_BITS:0] ballYEnd;
    logic [`PONG_POS_BITS:0] player1End;
    logic [`PONG_POS_BITS:0] player2End;

    logic leftHit;
    logic rightHit;
    logic player1Covers;
    logic player2Covers;

    // Far edges of ball and paddles along Y
    assign ballYEnd   = {1'b0, ballYPos} + {1'b0, posT'(`PONG_BALL_SIZE)};
    assign player1End = {1'b0, player1Pos} + {1'b0, posT'(`PONG_PADDLE_LEN)};
    assign player2End = {1'b0, player2Pos} + {1'b0, posT'(`PONG_PADDLE_LEN)};

    // Player 1 guards the low X side, player 2 the high X side
    assign leftHit  = ballXPos <= posT'(`PONG_BALL_X_MIN);
    assign rightHit = ballXPos >= posT'(`PONG_BALL_X_MAX);

    // Paddle and ball overlap in Y
    assign player1Covers = ({1'b0, player1Pos} < ballYEnd) &&
                           (player1End > {1'b0, ballYPos});
    assign player2Covers = ({1'b0, player2Pos} < ballYEnd) &&
                           (player2End > {1'b0, ballYPos});

    // Flags are captured once per frame at the end of the check phase
    always_ff @(posedge pixIf_CLK) begin
        if (reset) begin
            sideHit   <= 1'b0;
            bounceHit <= 1'b0;
            gameOver  <= 1'b0;
        end else if (phase == PHASE_CHECK) begin
            sideHit   <= leftHit || rightHit;
            bounceHit <= (ballYPos == '0) || (ballYPos >= posT'(`PONG_BALL_Y_MAX));
            // Miss when the paddle on the hit side is elsewhere
            gameOver  <= (leftHit && !player1Covers) ||
                         (rightHit && !player2Covers);
        end
    end

    // Previous frame has finished writing before the flags are captured
    assert property (@(posedge pixIf_CLK) disable iff (reset)
        phase == PHASE_CHECK |-> $stable({ballXPos, ballYPos, player1Pos, player2Pos}));

endmodule

`default_nettype wire

//--- src/pongFrameSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pongFrameSequencer
    import pongPkg::*;
(
    input  logic     pixIf_CLK,
    input  logic     reset,
    input  logic     pixIf_NEXT_FRAME,
    input  logic     player1YUp,
    input  logic     player1YDown,
    input  logic     player2YUp,
    input  logic     player2YDown,
    output seqPhaseT phase,
    output logic     p1Up,
    output logic     p1Down,
    output logic     p2Up,
    output logic     p2Down
);

    seqPhaseT nextPhase;

    // Fixed update order, idle waits for the strobe
    always_comb begin
        case (phase)
            PHASE_CHECK:    nextPhase = PHASE_TURN;
            PHASE_TURN:     nextPhase = PHASE_ISSUE_BX;
            PHASE_ISSUE_BX: nextPhase = PHASE_ISSUE_BY;
            PHASE_ISSUE_BY: nextPhase = PHASE_ISSUE_P1;
            PHASE_ISSUE_P1: nextPhase = PHASE_ISSUE_P2;
            default:        nextPhase = PHASE_IDLE;
        endcase
    end

    // Phase register
    always_ff @(posedge pixIf_CLK) begin
        if (reset) begin
            phase <= PHASE_IDLE;
        end else if (pixIf_NEXT_FRAME) begin
            // A strobe always restarts at the check
            phase <= PHASE_CHECK;
        end else begin
            phase <= nextPhase;
        end
    end

    // Button snapshot, held for the whole frame update
    always_ff @(posedge pixIf_CLK) begin
        if (reset) begin
            p1Up   <= 1'b0;
            p1Down <= 1'b0;
            p2Up   <= 1'b0;
            p2Down <= 1'b0;
        end else if (pixIf_NEXT_FRAME) begin
            p1Up   <= player1YUp;
            p1Down <= player1YDown;
            p2Up   <= player2YUp;
            p2Down <= player2YDown;
        end
    end

    // Sequence is back in idle at most seven samples later, or restarted
    assert property (@(posedge pixIf_CLK) disable iff (reset)
        pixIf_NEXT_FRAME |-> ##[1:7] (phase == PHASE_IDLE || pixIf_NEXT_FRAME));

endmodule

`default_nettype wire

//--- src/pongPkg.sv
`default_nettype none

`include "pong_cfg.svh"

package pongPkg;

    // One coordinate, origin at the upper left corner
    typedef logic [`PONG_POS_BITS-1:0] posT;

    // Tag that names the coordinate a step belongs to
    typedef enum logic [1:0] {
        STEP_BALL_X,
        STEP_BALL_Y,
        STEP_PADDLE1,
        STEP_PADDLE2
    } stepSelT;

    // Update phases, one per clock after the frame strobe
    typedef enum logic [2:0] {
        PHASE_IDLE,
        PHASE_CHECK,
        PHASE_TURN,
        // Issue phases feed the step pipeline back to back
        PHASE_ISSUE_BX,
        PHASE_ISSUE_BY,
        PHASE_ISSUE_P1,
        PHASE_ISSUE_P2
    } seqPhaseT;

endpackage

`default_nettype wire

//--- src/pong_cfg.svh
`ifndef PONG_CFG_SVH
`define PONG_CFG_SVH

// Playfield size in pixels
`define PONG_WIDTH 160
`define PONG_HEIGHT 120

// Object sizes in pixels
`define PONG_BALL_SIZE 4
`define PONG_PADDLE_LEN 16
`define PONG_PADDLE_WID 4

// Movement per frame
`define PONG_PADDLE_SPEED 2
`define PONG_BALL_SPEED 3

// Every coordinate shares this width
`define PONG_POS_BITS 8

// Ball travel limits, the paddles sit at both X ends
`define PONG_BALL_X_MIN (`PONG_PADDLE_WID)
`define PONG_BALL_X_MAX (`PONG_WIDTH - `PONG_BALL_SIZE - `PONG_PADDLE_WID)
`define PONG_BALL_Y_MAX (`PONG_HEIGHT - `PONG_BALL_SIZE)
`define PONG_PADDLE_MAX (`PONG_HEIGHT - `PONG_PADDLE_LEN)

// Start and serve positions
`define PONG_PADDLE_START (`PONG_PADDLE_MAX / 2)
`define PONG_BALL_START_X ((`PONG_WIDTH - `PONG_BALL_SIZE) / 2)
`define PONG_BALL_START_Y (`PONG_BALL_Y_MAX / 2)
// Serve away from the player who missed, gives some reaction time
`define PONG_SERVE_X_P1 (`PONG_BALL_START_X + `PONG_BALL_START_X / 2)
`define PONG_SERVE_X_P2 (`PONG_BALL_START_X - `PONG_BALL_START_X / 2)

`endif
